//--- bench/ooo_checker.sv
module ooo_checker #(
    parameter int ROWS = 1
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       instr_req_i,
    input logic                       instr_ack_i,
    input logic                       commit_valid_i,
    input logic [ooo_pkg::AREG_W-1:0] commit_rd_i,
    input logic [ooo_pkg::DATA_W-1:0] commit_data_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int   commits      = 0;
    int   passed       = 0;
    int   errors       = 0;
    logic out_of_reset = 1'b0;
    logic seen_req     = 1'b0;  // Set once the first request is sampled

    // Compares one commit with its table row
    task automatic check_row(input int row);
        logic ok;
        ok = 1'b1;
        if (commit_rd_i !== tb_ooo_core.exp_rd[row]) begin
            $display("ERR row %0d commit_rd_o got %h expected %h", row, commit_rd_i,
                     tb_ooo_core.exp_rd[row]);
            ok = 1'b0;
        end
        // Data of an x0 write is dropped by the core
        if (tb_ooo_core.exp_rd[row] != '0 && commit_data_i !== tb_ooo_core.exp_data[row]) begin
            $display("ERR row %0d commit_data_o got %h expected %h", row, commit_data_i,
                     tb_ooo_core.exp_data[row]);
            ok = 1'b0;
        end
        if (ok) begin
            passed++;
            $display("row %0d ok rd %0d data %h", row, commit_rd_i, commit_data_i);
        end else begin
            errors++;
        end
    endtask

    always @(posedge clk) begin
        out_of_reset <= !rst;
        if (instr_req_i) begin
            seen_req <= 1'b1;
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (out_of_reset && !seen_req && (instr_ack_i !== 1'b0 || commit_valid_i !== 1'b0)) begin
            $display("Core outputs went active before any request (ack %b, commit_valid %b)",
                     instr_ack_i, commit_valid_i);
            errors++;
        end
        if (commit_valid_i === 1'b1) begin
            if (commits >= ROWS) begin
                $display("Extra commit after the last row, rd %0d", commit_rd_i);
                errors++;
            end else begin
                check_row(commits);
            end
            commits++;
        end
    end

endmodule

//--- bench/tb_ooo_core.sv
module tb_ooo_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS       = 24;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + 100;

    logic                       clk;
    logic                       rst;
    logic                       instr_req;
    ooo_pkg::alu_op_e           op;
    logic [ooo_pkg::AREG_W-1:0] rd;
    logic [ooo_pkg::AREG_W-1:0] rs1;
    logic [ooo_pkg::AREG_W-1:0] rs2;
    logic [ooo_pkg::DATA_W-1:0] imm;
    logic                       instr_ack;
    logic                       commit_valid;
    logic [ooo_pkg::AREG_W-1:0] commit_rd;
    logic [ooo_pkg::DATA_W-1:0] commit_data;

    // Stimulus columns
    ooo_pkg::alu_op_e           tbl_op   [NUM_ROWS];
    logic [ooo_pkg::AREG_W-1:0] tbl_rd   [NUM_ROWS];
    logic [ooo_pkg::AREG_W-1:0] tbl_rs1  [NUM_ROWS];
    logic [ooo_pkg::AREG_W-1:0] tbl_rs2  [NUM_ROWS];
    logic [ooo_pkg::DATA_W-1:0] tbl_imm  [NUM_ROWS];
    // Expected commit columns, read by the checker
    logic [ooo_pkg::AREG_W-1:0] exp_rd   [NUM_ROWS];
    logic [ooo_pkg::DATA_W-1:0] exp_data [NUM_ROWS];

    logic [ooo_pkg::DATA_W-1:0] arch [ooo_pkg::ARCH_REGS];  // Architectural model state
    int                         n_rows;
    integer                     seed = 32'h98436b66;
    int                         idle;

    ooo_core ooo_core_i (
        .clk            (clk),
        .rst            (rst),
        .instr_req_i    (instr_req),
        .op_i           (op),
        .rd_i           (rd),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .imm_i          (imm),
        .instr_ack_o    (instr_ack),
        .commit_valid_o (commit_valid),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data)
    );

    ooo_checker #(.ROWS(NUM_ROWS)) ooo_checker_i (
        .clk            (clk),
        .rst            (rst),
        .instr_req_i    (instr_req),
        .instr_ack_i    (instr_ack),
        .commit_valid_i (commit_valid),
        .commit_rd_i    (commit_rd),
        .commit_data_i  (commit_data)
    );

    // Appends one micro-op and its architectural result
    task automatic add_row(input ooo_pkg::alu_op_e o, input int d, input int s1, input int s2,
                           input int im);
        logic [ooo_pkg::DATA_W-1:0] a;
        logic [ooo_pkg::DATA_W-1:0] b;
        a = arch[s1];
        b = (o == ooo_pkg::OP_ADDI) ? im : arch[s2];
        tbl_op[n_rows]   = o;
        tbl_rd[n_rows]   = ooo_pkg::AREG_W'(d);
        tbl_rs1[n_rows]  = ooo_pkg::AREG_W'(s1);
        tbl_rs2[n_rows]  = ooo_pkg::AREG_W'(s2);
        tbl_imm[n_rows]  = im;
        exp_rd[n_rows]   = ooo_pkg::AREG_W'(d);
        exp_data[n_rows] = (o == ooo_pkg::OP_SUB) ? a - b : a + b;
        if (d != 0) begin
            arch[d] = exp_data[n_rows];  // x0 keeps reading zero
        end
        n_rows++;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst       = 1'b1;
        instr_req = 1'b0;
        op        = ooo_pkg::OP_ADD;
        rd        = '0;
        rs1       = '0;
        rs2       = '0;
        imm       = '0;
        n_rows    = 0;
        for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
            arch[i] = '0;
        end
        // Independent ops, negative immediates
        add_row(ooo_pkg::OP_ADDI, 1, 0, 0, 5);
        add_row(ooo_pkg::OP_ADDI, 2, 0, 0, -3);
        add_row(ooo_pkg::OP_ADDI, 3, 0, 0, 100);
        add_row(ooo_pkg::OP_ADD,  4, 1, 2, 0);
        add_row(ooo_pkg::OP_SUB,  5, 3, 1, 0);
        add_row(ooo_pkg::OP_ADDI, 6, 0, 0, -1000);
        // Back-to-back chain through r1
        add_row(ooo_pkg::OP_ADDI, 1, 1, 0, 1);
        add_row(ooo_pkg::OP_ADD,  1, 1, 1, 0);
        add_row(ooo_pkg::OP_SUB,  1, 1, 2, 0);
        add_row(ooo_pkg::OP_ADDI, 1, 1, 0, -7);
        add_row(ooo_pkg::OP_ADD,  7, 1, 6, 0);
        // Writes to x0, then reads of x0
        add_row(ooo_pkg::OP_ADDI, 0, 3, 0, 55);
        add_row(ooo_pkg::OP_ADD,  0, 1, 1, 0);
        add_row(ooo_pkg::OP_ADD,  2, 0, 3, 0);
        add_row(ooo_pkg::OP_SUB,  3, 0, 3, 0);
        // Many rewrites of r4 and r5 to recycle physical registers
        add_row(ooo_pkg::OP_ADDI, 4, 4, 0, 3);
        add_row(ooo_pkg::OP_ADDI, 5, 4, 0, 2);
        add_row(ooo_pkg::OP_SUB,  4, 5, 4, 0);
        add_row(ooo_pkg::OP_ADDI, 4, 4, 0, 16);
        add_row(ooo_pkg::OP_ADD,  5, 5, 4, 0);
        add_row(ooo_pkg::OP_ADDI, 4, 5, 0, -9);
        add_row(ooo_pkg::OP_SUB,  5, 4, 7, 0);
        add_row(ooo_pkg::OP_ADD,  6, 5, 2, 0);
        add_row(ooo_pkg::OP_ADDI, 7, 6, 0, 12);

        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);  // Quiet window before the first request

        for (int r = 0; r < NUM_ROWS; r++) begin
            op        = tbl_op[r];
            rd        = tbl_rd[r];
            rs1       = tbl_rs1[r];
            rs2       = tbl_rs2[r];
            imm       = tbl_imm[r];
            instr_req = 1'b1;
            @(negedge clk);
            while (!instr_ack) @(negedge clk);  // Held through back-pressure
            instr_req = 1'b0;
            @(negedge clk);
            while (instr_ack) @(negedge clk);
            idle = $unsigned($random(seed)) % 4;
            repeat (idle) @(negedge clk);
        end

        while (ooo_checker_i.commits < NUM_ROWS) @(posedge clk);
        repeat (20) @(posedge clk);  // Room for a stray extra commit
        $display("%0d of %0d rows correct, %0d commits, %0d errors", ooo_checker_i.passed,
                 NUM_ROWS, ooo_checker_i.commits, ooo_checker_i.errors);
        if (ooo_checker_i.errors == 0 && ooo_checker_i.commits == NUM_ROWS) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, only %0d of %0d commits seen, commits are missing",
                 TIMEOUT_CYCLES, ooo_checker_i.commits, NUM_ROWS);
        $display("tests failed");
        $finish;
    end

endmodule

//--- files.f
hw/ooo_pkg.sv
hw/rename_unit.sv
hw/reorder_buffer.sv
hw/issue_queue.sv
hw/phys_regfile.sv
hw/int_alu.sv
hw/ooo_core.sv
bench/ooo_checker.sv
bench/tb_ooo_core.sv

//--- hw/int_alu.sv
module int_alu (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       issue_valid_i,
    input  ooo_pkg::alu_op_e           issue_op_i,
    input  logic [ooo_pkg::DATA_W-1:0] issue_a_i,
    input  logic [ooo_pkg::DATA_W-1:0] issue_b_i,
    input  logic [ooo_pkg::PREG_W-1:0] issue_preg_i,
    input  logic [ooo_pkg::ROB_W-1:0]  issue_rob_idx_i,
    output logic                       wb_valid_o,
    output logic [ooo_pkg::PREG_W-1:0] wb_preg_o,
    output logic [ooo_pkg::ROB_W-1:0]  wb_rob_idx_o,
    output logic [ooo_pkg::DATA_W-1:0] wb_data_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= issue_valid_i;
        end
    end

    // Result and tags, qualified by wb_valid_o
    always_ff @(posedge clk) begin
        wb_preg_o    <= issue_preg_i;
        wb_rob_idx_o <= issue_rob_idx_i;
        if (issue_op_i == ooo_pkg::OP_SUB) begin
            wb_data_o <= issue_a_i - issue_b_i;
        end else begin
            wb_data_o <= issue_a_i + issue_b_i;  // ADD and ADDI
        end
    end

endmodule

//--- hw/issue_queue.sv
module issue_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       disp_valid_i,
    input  ooo_pkg::alu_op_e           disp_op_i,
    input  logic [ooo_pkg::PREG_W-1:0] disp_preg_i,
    input  logic [ooo_pkg::PREG_W-1:0] disp_psrc1_i,
    input  logic [ooo_pkg::PREG_W-1:0] disp_psrc2_i,
    input  logic [ooo_pkg::DATA_W-1:0] disp_imm_i,
    input  logic [ooo_pkg::ROB_W-1:0]  disp_rob_idx_i,
    input  logic [ooo_pkg::DATA_W-1:0] rd1_data_i,
    input  logic                       rd1_ready_i,
    input  logic [ooo_pkg::DATA_W-1:0] rd2_data_i,
    input  logic                       rd2_ready_i,
    input  logic                       wb_valid_i,
    input  logic [ooo_pkg::PREG_W-1:0] wb_preg_i,
    input  logic [ooo_pkg::DATA_W-1:0] wb_data_i,
    output logic                       iq_full_o,
    output logic [ooo_pkg::PREG_W-1:0] rd1_addr_o,
    output logic [ooo_pkg::PREG_W-1:0] rd2_addr_o,
    output logic                       issue_valid_o,
    output ooo_pkg::alu_op_e           issue_op_o,
    output logic [ooo_pkg::DATA_W-1:0] issue_a_o,
    output logic [ooo_pkg::DATA_W-1:0] issue_b_o,
    output logic [ooo_pkg::PREG_W-1:0] issue_preg_o,
    output logic [ooo_pkg::ROB_W-1:0]  issue_rob_idx_o
);

    logic [ooo_pkg::IQ_DEPTH-1:0]       slot_valid;
    logic [ooo_pkg::IQ_DEPTH-1:0]       rdy1;
    logic [ooo_pkg::IQ_DEPTH-1:0]       rdy2;
    logic [ooo_pkg::IQ_DEPTH-1:0]       can_issue;
    ooo_pkg::alu_op_e                   op      [ooo_pkg::IQ_DEPTH];
    logic [ooo_pkg::PREG_W-1:0]         dst     [ooo_pkg::IQ_DEPTH];
    logic [ooo_pkg::PREG_W-1:0]         src1    [ooo_pkg::IQ_DEPTH];
    logic [ooo_pkg::PREG_W-1:0]         src2    [ooo_pkg::IQ_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]         val1    [ooo_pkg::IQ_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]         val2    [ooo_pkg::IQ_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]         imm     [ooo_pkg::IQ_DEPTH];
    logic [ooo_pkg::ROB_W-1:0]          rob_idx [ooo_pkg::IQ_DEPTH];
    logic [$clog2(ooo_pkg::IQ_DEPTH)-1:0] age   [ooo_pkg::IQ_DEPTH];  // Younger valid entries
    int                                 free_idx;
    int                                 sel_idx;
    logic                               byp1;
    logic                               byp2;

    assign rd1_addr_o = disp_psrc1_i;
    assign rd2_addr_o = disp_psrc2_i;
    assign byp1       = wb_valid_i && (wb_preg_i == disp_psrc1_i);  // Same-cycle result
    assign byp2       = wb_valid_i && (wb_preg_i == disp_psrc2_i);
    assign iq_full_o  = &slot_valid;

    always_comb begin
        free_idx = 0;
        sel_idx  = 0;
        for (int i = ooo_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx = i;
            end
        end
        for (int i = 0; i < ooo_pkg::IQ_DEPTH; i++) begin
            can_issue[i] = slot_valid[i] && rdy1[i] && (op[i] == ooo_pkg::OP_ADDI || rdy2[i]);
        end
        for (int i = 0; i < ooo_pkg::IQ_DEPTH; i++) begin
            if (can_issue[i] && (!can_issue[sel_idx] || age[i] > age[sel_idx])) begin
                sel_idx = i;  // Oldest ready wins
            end
        end
    end

    assign issue_valid_o   = |can_issue;
    assign issue_op_o      = op[sel_idx];
    assign issue_a_o       = val1[sel_idx];
    assign issue_b_o       = (op[sel_idx] == ooo_pkg::OP_ADDI) ? imm[sel_idx] : val2[sel_idx];
    assign issue_preg_o    = dst[sel_idx];
    assign issue_rob_idx_o = rob_idx[sel_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < ooo_pkg::IQ_DEPTH; i++) begin
                if (slot_valid[i] && wb_valid_i && !rdy1[i] && wb_preg_i == src1[i]) begin
                    rdy1[i] <= 1'b1;
                    val1[i] <= wb_data_i;
                end
                if (slot_valid[i] && wb_valid_i && !rdy2[i] && wb_preg_i == src2[i]) begin
                    rdy2[i] <= 1'b1;
                    val2[i] <= wb_data_i;
                end
                // Keep age equal to the count of younger entries
                if (slot_valid[i]) begin
                    if (disp_valid_i && !(issue_valid_o && age[i] > age[sel_idx])) begin
                        age[i] <= age[i] + 1'b1;
                    end else if (!disp_valid_i && issue_valid_o && age[i] > age[sel_idx]) begin
                        age[i] <= age[i] - 1'b1;
                    end
                end
            end
            if (issue_valid_o) begin
                slot_valid[sel_idx] <= 1'b0;
            end
            if (disp_valid_i) begin
                slot_valid[free_idx] <= 1'b1;
                op[free_idx]         <= disp_op_i;
                dst[free_idx]        <= disp_preg_i;
                src1[free_idx]       <= disp_psrc1_i;
                src2[free_idx]       <= disp_psrc2_i;
                imm[free_idx]        <= disp_imm_i;
                rob_idx[free_idx]    <= disp_rob_idx_i;
                age[free_idx]        <= '0;
                rdy1[free_idx]       <= rd1_ready_i || byp1;
                rdy2[free_idx]       <= rd2_ready_i || byp2;
                val1[free_idx]       <= rd1_ready_i ? rd1_data_i : wb_data_i;
                val2[free_idx]       <= rd2_ready_i ? rd2_data_i : wb_data_i;
            end
        end
    end

    // An issued operand is never a result that is only now on the writeback bus
    issue_operands_ready: assert property (@(posedge clk) disable iff (rst)
        issue_valid_o && wb_valid_i && wb_preg_i != '0 |->
            wb_preg_i != src1[sel_idx]
            && (issue_op_o == ooo_pkg::OP_ADDI || wb_preg_i != src2[sel_idx]));

endmodule

//--- hw/ooo_core.sv
module ooo_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instr_req_i,
    input  ooo_pkg::alu_op_e           op_i,
    input  logic [ooo_pkg::AREG_W-1:0] rd_i,
    input  logic [ooo_pkg::AREG_W-1:0] rs1_i,
    input  logic [ooo_pkg::AREG_W-1:0] rs2_i,
    input  logic [ooo_pkg::DATA_W-1:0] imm_i,
    output logic                       instr_ack_o,
    output logic                       commit_valid_o,
    output logic [ooo_pkg::AREG_W-1:0] commit_rd_o,
    output logic [ooo_pkg::DATA_W-1:0] commit_data_o
);

    // Dispatch
    logic                       disp_valid;
    ooo_pkg::alu_op_e           disp_op;
    logic [ooo_pkg::AREG_W-1:0] disp_rd;
    logic [ooo_pkg::PREG_W-1:0] disp_preg;
    logic [ooo_pkg::PREG_W-1:0] disp_old_preg;
    logic [ooo_pkg::PREG_W-1:0] disp_psrc1;
    logic [ooo_pkg::PREG_W-1:0] disp_psrc2;
    logic [ooo_pkg::DATA_W-1:0] disp_imm;
    logic [ooo_pkg::ROB_W-1:0]  disp_rob_idx;
    logic                       rob_full;
    logic                       iq_full;
    logic [ooo_pkg::PREG_W-1:0] commit_old_preg;

    // Register file reads at dispatch
    logic [ooo_pkg::PREG_W-1:0] rd1_addr;
    logic [ooo_pkg::PREG_W-1:0] rd2_addr;
    logic [ooo_pkg::DATA_W-1:0] rd1_data;
    logic [ooo_pkg::DATA_W-1:0] rd2_data;
    logic                       rd1_ready;
    logic                       rd2_ready;

    // Issue and writeback
    logic                       issue_valid;
    ooo_pkg::alu_op_e           issue_op;
    logic [ooo_pkg::DATA_W-1:0] issue_a;
    logic [ooo_pkg::DATA_W-1:0] issue_b;
    logic [ooo_pkg::PREG_W-1:0] issue_preg;
    logic [ooo_pkg::ROB_W-1:0]  issue_rob_idx;
    logic                       wb_valid;
    logic [ooo_pkg::PREG_W-1:0] wb_preg;
    logic [ooo_pkg::ROB_W-1:0]  wb_rob_idx;
    logic [ooo_pkg::DATA_W-1:0] wb_data;

    rename_unit rename_unit_i (
        .clk               (clk),
        .rst               (rst),
        .instr_req_i       (instr_req_i),
        .op_i              (op_i),
        .rd_i              (rd_i),
        .rs1_i             (rs1_i),
        .rs2_i             (rs2_i),
        .imm_i             (imm_i),
        .rob_full_i        (rob_full),
        .iq_full_i         (iq_full),
        .commit_valid_i    (commit_valid_o),
        .commit_old_preg_i (commit_old_preg),
        .instr_ack_o       (instr_ack_o),
        .disp_valid_o      (disp_valid),
        .disp_op_o         (disp_op),
        .disp_rd_o         (disp_rd),
        .disp_preg_o       (disp_preg),
        .disp_old_preg_o   (disp_old_preg),
        .disp_psrc1_o      (disp_psrc1),
        .disp_psrc2_o      (disp_psrc2),
        .disp_imm_o        (disp_imm)
    );

    reorder_buffer reorder_buffer_i (
        .clk               (clk),
        .rst               (rst),
        .disp_valid_i      (disp_valid),
        .disp_rd_i         (disp_rd),
        .disp_old_preg_i   (disp_old_preg),
        .wb_valid_i        (wb_valid),
        .wb_rob_idx_i      (wb_rob_idx),
        .wb_data_i         (wb_data),
        .rob_full_o        (rob_full),
        .disp_rob_idx_o    (disp_rob_idx),
        .commit_valid_o    (commit_valid_o),
        .commit_rd_o       (commit_rd_o),
        .commit_data_o     (commit_data_o),
        .commit_old_preg_o (commit_old_preg)
    );

    issue_queue issue_queue_i (
        .clk             (clk),
        .rst             (rst),
        .disp_valid_i    (disp_valid),
        .disp_op_i       (disp_op),
        .disp_preg_i     (disp_preg),
        .disp_psrc1_i    (disp_psrc1),
        .disp_psrc2_i    (disp_psrc2),
        .disp_imm_i      (disp_imm),
        .disp_rob_idx_i  (disp_rob_idx),
        .rd1_data_i      (rd1_data),
        .rd1_ready_i     (rd1_ready),
        .rd2_data_i      (rd2_data),
        .rd2_ready_i     (rd2_ready),
        .wb_valid_i      (wb_valid),
        .wb_preg_i       (wb_preg),
        .wb_data_i       (wb_data),
        .iq_full_o       (iq_full),
        .rd1_addr_o      (rd1_addr),
        .rd2_addr_o      (rd2_addr),
        .issue_valid_o   (issue_valid),
        .issue_op_o      (issue_op),
        .issue_a_o       (issue_a),
        .issue_b_o       (issue_b),
        .issue_preg_o    (issue_preg),
        .issue_rob_idx_o (issue_rob_idx)
    );

    phys_regfile phys_regfile_i (
        .clk           (clk),
        .rst           (rst),
        .rd1_addr_i    (rd1_addr),
        .rd2_addr_i    (rd2_addr),
        .alloc_valid_i (disp_valid),
        .alloc_preg_i  (disp_preg),
        .wr_valid_i    (wb_valid),
        .wr_preg_i     (wb_preg),
        .wr_data_i     (wb_data),
        .rd1_data_o    (rd1_data),
        .rd1_ready_o   (rd1_ready),
        .rd2_data_o    (rd2_data),
        .rd2_ready_o   (rd2_ready)
    );

    int_alu int_alu_i (
        .clk             (clk),
        .rst             (rst),
        .issue_valid_i   (issue_valid),
        .issue_op_i      (issue_op),
        .issue_a_i       (issue_a),
        .issue_b_i       (issue_b),
        .issue_preg_i    (issue_preg),
        .issue_rob_idx_i (issue_rob_idx),
        .wb_valid_o      (wb_valid),
        .wb_preg_o       (wb_preg),
        .wb_rob_idx_o    (wb_rob_idx),
        .wb_data_o       (wb_data)
    );

endmodule

//--- hw/ooo_pkg.sv
package ooo_pkg;

    // Datapath
    localparam int DATA_W = 32;

    // Architectural and physical register files
    localparam int ARCH_REGS = 8;
    localparam int AREG_W    = $clog2(ARCH_REGS);
    localparam int PHYS_REGS = 16;
    localparam int PREG_W    = $clog2(PHYS_REGS);

    // Window sizes
    localparam int ROB_DEPTH = 8;
    localparam int ROB_W     = $clog2(ROB_DEPTH);
    localparam int IQ_DEPTH  = 4;

    // Decoded micro-op kinds handled by the integer ALU
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_ADDI = 2'd2  // Second operand is the immediate
    } alu_op_e;

endpackage

//--- hw/phys_regfile.sv
module phys_regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [ooo_pkg::PREG_W-1:0] rd1_addr_i,
    input  logic [ooo_pkg::PREG_W-1:0] rd2_addr_i,
    input  logic                       alloc_valid_i,
    input  logic [ooo_pkg::PREG_W-1:0] alloc_preg_i,
    input  logic                       wr_valid_i,
    input  logic [ooo_pkg::PREG_W-1:0] wr_preg_i,
    input  logic [ooo_pkg::DATA_W-1:0] wr_data_i,
    output logic [ooo_pkg::DATA_W-1:0] rd1_data_o,
    output logic                       rd1_ready_o,
    output logic [ooo_pkg::DATA_W-1:0] rd2_data_o,
    output logic                       rd2_ready_o
);

    logic [ooo_pkg::DATA_W-1:0]    regs [ooo_pkg::PHYS_REGS];
    logic [ooo_pkg::PHYS_REGS-1:0] ready;

    // p0 is hardwired zero
    assign rd1_data_o  = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd1_ready_o = (rd1_addr_i == '0) || ready[rd1_addr_i];
    assign rd2_data_o  = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];
    assign rd2_ready_o = (rd2_addr_i == '0) || ready[rd2_addr_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::PHYS_REGS; i++) begin
                regs[i]  <= '0;
                ready[i] <= (i < ooo_pkg::ARCH_REGS);  // Initial mappings hold zero
            end
        end else begin
            if (alloc_valid_i && alloc_preg_i != '0) begin
                ready[alloc_preg_i] <= 1'b0;  // Pending producer
            end
            if (wr_valid_i && wr_preg_i != '0) begin
                regs[wr_preg_i]  <= wr_data_i;
                ready[wr_preg_i] <= 1'b1;
            end
        end
    end

endmodule

//--- hw/rename_unit.sv
module rename_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instr_req_i,
    input  ooo_pkg::alu_op_e           op_i,
    input  logic [ooo_pkg::AREG_W-1:0] rd_i,
    input  logic [ooo_pkg::AREG_W-1:0] rs1_i,
    input  logic [ooo_pkg::AREG_W-1:0] rs2_i,
    input  logic [ooo_pkg::DATA_W-1:0] imm_i,
    input  logic                       rob_full_i,
    input  logic                       iq_full_i,
    input  logic                       commit_valid_i,
    input  logic [ooo_pkg::PREG_W-1:0] commit_old_preg_i,
    output logic                       instr_ack_o,
    output logic                       disp_valid_o,
    output ooo_pkg::alu_op_e           disp_op_o,
    output logic [ooo_pkg::AREG_W-1:0] disp_rd_o,
    output logic [ooo_pkg::PREG_W-1:0] disp_preg_o,
    output logic [ooo_pkg::PREG_W-1:0] disp_old_preg_o,
    output logic [ooo_pkg::PREG_W-1:0] disp_psrc1_o,
    output logic [ooo_pkg::PREG_W-1:0] disp_psrc2_o,
    output logic [ooo_pkg::DATA_W-1:0] disp_imm_o
);

    logic [ooo_pkg::PREG_W-1:0] rat [ooo_pkg::ARCH_REGS];     // Arch to phys mapping
    logic [ooo_pkg::PREG_W-1:0] fl_mem [ooo_pkg::PHYS_REGS];  // Free list ring
    logic [ooo_pkg::PREG_W-1:0] fl_head;
    logic [ooo_pkg::PREG_W-1:0] fl_tail;
    logic [ooo_pkg::PREG_W:0]   fl_count;
    logic                       fl_push;
    logic                       fl_pop;

    // Accept on the first cycle of a new request with room everywhere
    assign disp_valid_o = instr_req_i && !instr_ack_o && !rob_full_i && !iq_full_i
                          && (fl_count != '0);

    assign fl_pop  = disp_valid_o && (rd_i != '0);
    assign fl_push = commit_valid_i && (commit_old_preg_i != '0);  // x0 never recycled

    assign disp_op_o       = op_i;
    assign disp_rd_o       = rd_i;
    assign disp_imm_o      = imm_i;
    assign disp_psrc1_o    = rat[rs1_i];
    assign disp_psrc2_o    = rat[rs2_i];
    assign disp_preg_o     = (rd_i != '0) ? fl_mem[fl_head] : '0;
    assign disp_old_preg_o = rat[rd_i];  // Entry 0 stays mapped to p0

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_ack_o <= 1'b0;
            for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
                rat[i] <= ooo_pkg::PREG_W'(i);  // Identity map
            end
            for (int i = 0; i < ooo_pkg::PHYS_REGS - ooo_pkg::ARCH_REGS; i++) begin
                fl_mem[i] <= ooo_pkg::PREG_W'(ooo_pkg::ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= ooo_pkg::PREG_W'(ooo_pkg::PHYS_REGS - ooo_pkg::ARCH_REGS);
            fl_count <= (ooo_pkg::PREG_W + 1)'(ooo_pkg::PHYS_REGS - ooo_pkg::ARCH_REGS);
        end else begin
            if (disp_valid_o) begin
                instr_ack_o <= 1'b1;
            end else if (!instr_req_i) begin
                instr_ack_o <= 1'b0;  // Return to zero phase
            end
            if (fl_pop) begin
                rat[rd_i] <= fl_mem[fl_head];
                fl_head   <= fl_head + 1'b1;
            end
            if (fl_push) begin
                fl_mem[fl_tail] <= commit_old_preg_i;
                fl_tail         <= fl_tail + 1'b1;
            end
            case ({fl_push, fl_pop})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

    // A pop from an empty list would wrap the count past this bound,
    // and so would the ROB handing back a register it never took
    free_list_bounded: assert property (@(posedge clk) disable iff (rst)
        fl_count <= (ooo_pkg::PHYS_REGS - ooo_pkg::ARCH_REGS));

endmodule

//--- hw/reorder_buffer.sv
module reorder_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       disp_valid_i,
    input  logic [ooo_pkg::AREG_W-1:0] disp_rd_i,
    input  logic [ooo_pkg::PREG_W-1:0] disp_old_preg_i,
    input  logic                       wb_valid_i,
    input  logic [ooo_pkg::ROB_W-1:0]  wb_rob_idx_i,
    input  logic [ooo_pkg::DATA_W-1:0] wb_data_i,
    output logic                       rob_full_o,
    output logic [ooo_pkg::ROB_W-1:0]  disp_rob_idx_o,
    output logic                       commit_valid_o,
    output logic [ooo_pkg::AREG_W-1:0] commit_rd_o,
    output logic [ooo_pkg::DATA_W-1:0] commit_data_o,
    output logic [ooo_pkg::PREG_W-1:0] commit_old_preg_o
);

    logic [ooo_pkg::AREG_W-1:0]    rd_mem   [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::PREG_W-1:0]    old_mem  [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]    data_mem [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_DEPTH-1:0] done;
    logic [ooo_pkg::ROB_W-1:0]     head;
    logic [ooo_pkg::ROB_W-1:0]     tail;
    logic [ooo_pkg::ROB_W:0]       count;
    logic                          head_ready;

    assign rob_full_o     = (count == (ooo_pkg::ROB_W + 1)'(ooo_pkg::ROB_DEPTH));
    assign disp_rob_idx_o = tail;
    assign head_ready     = (count != '0) && done[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            done           <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= head_ready;
            if (disp_valid_i) begin
                rd_mem[tail]  <= disp_rd_i;
                old_mem[tail] <= disp_old_preg_i;
                done[tail]    <= 1'b0;
                tail          <= tail + 1'b1;
            end
            if (wb_valid_i) begin
                data_mem[wb_rob_idx_i] <= wb_data_i;
                done[wb_rob_idx_i]     <= 1'b1;
            end
            if (head_ready) begin
                head <= head + 1'b1;  // Retire in program order
            end
            case ({disp_valid_i, head_ready})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Commit payload, qualified by commit_valid_o
    always_ff @(posedge clk) begin
        commit_rd_o       <= rd_mem[head];
        commit_data_o     <= data_mem[head];
        commit_old_preg_o <= old_mem[head];
    end

    // Rename must hold off dispatch while the window is full
    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        disp_valid_i |-> !rob_full_o);

endmodule
